// ==== icache.f ====
logic/icache_pkg.sv
logic/icache_way_if.sv
logic/icache_way.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache_cfg.sv
logic/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

// ==== logic/icache_cfg.sv ====
`timescale 1ns/10ps

module icache_cfg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_cfg_wr,
    input  icache_pkg::icache_reg_e      i_cfg_addr,
    input  logic [icache_pkg::CFG_W-1:0] i_cfg_wdata,
    output logic [icache_pkg::CFG_W-1:0] o_cfg_rdata,
    input  logic                         i_hit,
    input  logic                         i_miss,
    output logic                         o_enable,
    output logic                         o_flush
);
    import icache_pkg::*;

    logic [CFG_W-1:0] hit_cnt;
    logic [CFG_W-1:0] miss_cnt;

    // enable and flush strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_enable <= 1'b1;
            o_flush  <= 1'b0;
        end else begin
            o_flush <= i_cfg_wr && (i_cfg_addr == REG_CTRL) && i_cfg_wdata[1];
            if (i_cfg_wr && (i_cfg_addr == REG_CTRL)) begin
                o_enable <= i_cfg_wdata[0];
            end
        end
    end

    // a write wins over a count in the same cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else begin
            if (i_cfg_wr && (i_cfg_addr == REG_HITS)) begin
                hit_cnt <= '0;
            end else if (i_hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            if (i_cfg_wr && (i_cfg_addr == REG_MISSES)) begin
                miss_cnt <= '0;
            end else if (i_miss) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (i_cfg_addr)
            REG_CTRL:   o_cfg_rdata = {{(CFG_W-1){1'b0}}, o_enable};
            REG_HITS:   o_cfg_rdata = hit_cnt;
            REG_MISSES: o_cfg_rdata = miss_cnt;
            default:    o_cfg_rdata = '0;
        endcase
    end

endmodule

// ==== logic/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl #(
    parameter int SET_BITS = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_fetch_req,
    input  logic [icache_pkg::ADDR_W-1:0] i_fetch_addr,
    output logic                          o_fetch_valid,
    output logic [icache_pkg::INSN_W-1:0] o_fetch_data,
    output logic                          o_mem_req,
    output logic [icache_pkg::ADDR_W-1:0] o_mem_addr,
    input  logic                          i_mem_valid,
    input  logic [icache_pkg::LINE_W-1:0] i_mem_data,
    input  logic                          i_enable,
    input  logic                          i_flush,
    output logic                          o_hit,
    output logic                          o_miss,
    output logic [SET_BITS-1:0]           o_lru_index,
    output logic                          o_lru_touch,
    output logic                          o_lru_touch_way,
    input  logic                          i_lru_way,
    icache_way_if.ctrl                    way0,
    icache_way_if.ctrl                    way1
);
    import icache_pkg::*;

    localparam int TAG_W = ADDR_W - SET_BITS - 3;

    icache_state_e state;
    icache_state_e state_next;

    logic [ADDR_W-1:0]   addr_q;
    logic                fill_q;
    logic [TAG_W-1:0]    tag_q;
    logic [SET_BITS-1:0] set_q;
    logic [SET_BITS-1:0] index;
    logic                hit0;
    logic                hit1;
    logic                lookup_hit;
    logic                fill_now;
    logic                victim;
    logic [LINE_W-1:0]   hit_line;

    // pick the instruction named by address bit 2
    function automatic logic [INSN_W-1:0] half_sel(input logic [LINE_W-1:0] line,
                                                   input logic upper);
        return upper ? line[INSN_W +: INSN_W] : line[0 +: INSN_W];
    endfunction

    assign tag_q = addr_q[ADDR_W-1:SET_BITS+3];
    assign set_q = addr_q[SET_BITS+2:3];

    // new request index goes out straight away in IDLE
    assign index = (state == IDLE) ? i_fetch_addr[SET_BITS+2:3] : set_q;

    assign hit0       = way0.rd_valid && (way0.rd_tag == tag_q);
    assign hit1       = way1.rd_valid && (way1.rd_tag == tag_q);
    assign hit_line   = hit1 ? way1.rd_data : way0.rd_data;
    assign lookup_hit = (state == LOOKUP) && i_enable && (hit0 || hit1);
    assign fill_now   = (state == WAIT_MEM) && i_mem_valid && fill_q;

    // invalid way first, way0 before way1
    always_comb begin
        if (!way0.rd_valid) begin
            victim = 1'b0;
        end else if (!way1.rd_valid) begin
            victim = 1'b1;
        end else begin
            victim = i_lru_way;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_fetch_req) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                state_next = lookup_hit ? RESPOND : WAIT_MEM;
            end
            WAIT_MEM: begin
                if (i_mem_valid) begin
                    state_next = RESPOND;
                end
            end
            RESPOND: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= IDLE;
            o_mem_req <= 1'b0;
            fill_q    <= 1'b0;
        end else begin
            state     <= state_next;
            o_mem_req <= (state == LOOKUP) && !lookup_hit;
            // disabled fetches bypass and leave the ways alone
            if (state == LOOKUP) begin
                fill_q <= i_enable;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_fetch_req) begin
            addr_q <= i_fetch_addr;
        end
        if (lookup_hit) begin
            o_fetch_data <= half_sel(hit_line, addr_q[2]);
        end else if ((state == WAIT_MEM) && i_mem_valid) begin
            o_fetch_data <= half_sel(i_mem_data, addr_q[2]);
        end
    end

    assign o_fetch_valid = (state == RESPOND);
    assign o_mem_addr    = {addr_q[ADDR_W-1:3], 3'b000};

    // counter strobes line up with the edge that raises o_fetch_valid
    assign o_hit  = lookup_hit;
    assign o_miss = fill_now;

    assign o_lru_index     = set_q;
    assign o_lru_touch     = lookup_hit || fill_now;
    assign o_lru_touch_way = lookup_hit ? hit1 : victim;

    assign way0.index   = index;
    assign way0.wr_en   = fill_now && !victim;
    assign way0.wr_tag  = tag_q;
    assign way0.wr_data = i_mem_data;
    assign way0.flush   = i_flush;

    assign way1.index   = index;
    assign way1.wr_en   = fill_now && victim;
    assign way1.wr_tag  = tag_q;
    assign way1.wr_data = i_mem_data;
    assign way1.flush   = i_flush;

endmodule

// ==== logic/icache_lru.sv ====
`timescale 1ns/10ps

module icache_lru #(
    parameter int SET_BITS = 6
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [SET_BITS-1:0] i_index,
    input  logic                i_touch,
    input  logic                i_touch_way,
    output logic                o_lru_way
);

    localparam int SETS = 1 << SET_BITS;

    // one bit per set, names the least recently used way
    logic [SETS-1:0] lru;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lru <= '0;
        end else if (i_touch) begin
            // the other way becomes the oldest
            lru[i_index] <= ~i_touch_way;
        end
    end

    assign o_lru_way = lru[i_index];

endmodule

// ==== logic/icache_pkg.sv ====
package icache_pkg;

    // fetch address width
    localparam int ADDR_W = 32;

    // one line holds two instructions
    localparam int LINE_W = 64;

    localparam int INSN_W = 32;

    // configuration data width
    localparam int CFG_W = 32;

    // controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOOKUP   = 2'd1,
        WAIT_MEM = 2'd2,
        RESPOND  = 2'd3
    } icache_state_e;

    // configuration register map
    // REG_CTRL bit 0 enable, bit 1 flush on write
    // counters clear on any write
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_HITS   = 2'd1,
        REG_MISSES = 2'd2
    } icache_reg_e;

endpackage

// ==== logic/icache_top.sv ====
`timescale 1ns/10ps

module icache_top #(
    parameter int SET_BITS = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    // core side
    input  logic                          i_fetch_req,
    input  logic [icache_pkg::ADDR_W-1:0] i_fetch_addr,
    output logic                          o_fetch_valid,
    output logic [icache_pkg::INSN_W-1:0] o_fetch_data,
    // memory side
    output logic                          o_mem_req,
    output logic [icache_pkg::ADDR_W-1:0] o_mem_addr,
    input  logic                          i_mem_valid,
    input  logic [icache_pkg::LINE_W-1:0] i_mem_data,
    // configuration
    input  logic                          i_cfg_wr,
    input  icache_pkg::icache_reg_e       i_cfg_addr,
    input  logic [icache_pkg::CFG_W-1:0]  i_cfg_wdata,
    output logic [icache_pkg::CFG_W-1:0]  o_cfg_rdata
);

    logic                enable;
    logic                flush;
    logic                hit;
    logic                miss;
    logic [SET_BITS-1:0] lru_index;
    logic                lru_touch;
    logic                lru_touch_way;
    logic                lru_way;

    icache_way_if #(.SET_BITS(SET_BITS)) way0_if ();
    icache_way_if #(.SET_BITS(SET_BITS)) way1_if ();

    icache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_fetch_req     (i_fetch_req),
        .i_fetch_addr    (i_fetch_addr),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_data    (o_fetch_data),
        .o_mem_req       (o_mem_req),
        .o_mem_addr      (o_mem_addr),
        .i_mem_valid     (i_mem_valid),
        .i_mem_data      (i_mem_data),
        .i_enable        (enable),
        .i_flush         (flush),
        .o_hit           (hit),
        .o_miss          (miss),
        .o_lru_index     (lru_index),
        .o_lru_touch     (lru_touch),
        .o_lru_touch_way (lru_touch_way),
        .i_lru_way       (lru_way),
        .way0            (way0_if.ctrl),
        .way1            (way1_if.ctrl)
    );

    icache_way #(.SET_BITS(SET_BITS)) u_way0 (
        .clk    (clk),
        .rst    (rst),
        .way_if (way0_if.way)
    );

    icache_way #(.SET_BITS(SET_BITS)) u_way1 (
        .clk    (clk),
        .rst    (rst),
        .way_if (way1_if.way)
    );

    icache_lru #(.SET_BITS(SET_BITS)) u_lru (
        .clk         (clk),
        .rst         (rst),
        .i_index     (lru_index),
        .i_touch     (lru_touch),
        .i_touch_way (lru_touch_way),
        .o_lru_way   (lru_way)
    );

    icache_cfg u_cfg (
        .clk         (clk),
        .rst         (rst),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .i_hit       (hit),
        .i_miss      (miss),
        .o_enable    (enable),
        .o_flush     (flush)
    );

endmodule

// ==== logic/icache_way.sv ====
`timescale 1ns/10ps

module icache_way #(
    parameter int SET_BITS = 6
) (
    input  logic       clk,
    input  logic       rst,
    icache_way_if.way  way_if
);
    import icache_pkg::*;

    localparam int TAG_W = ADDR_W - SET_BITS - 3;
    localparam int SETS  = 1 << SET_BITS;

    logic [TAG_W-1:0]  tag_mem  [SETS];
    logic [LINE_W-1:0] data_mem [SETS];
    logic [SETS-1:0]   valid;

    // tag and data arrays, registered read
    always_ff @(posedge clk) begin
        if (way_if.wr_en) begin
            tag_mem[way_if.index]  <= way_if.wr_tag;
            data_mem[way_if.index] <= way_if.wr_data;
        end
        way_if.rd_tag  <= tag_mem[way_if.index];
        way_if.rd_data <= data_mem[way_if.index];
    end

    // valid bits live in flops so flush can clear them all at once
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else if (way_if.flush) begin
            valid <= '0;
        end else if (way_if.wr_en) begin
            valid[way_if.index] <= 1'b1;
        end
    end

    // valid read lines up with tag and data
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way_if.rd_valid <= 1'b0;
        end else begin
            way_if.rd_valid <= valid[way_if.index];
        end
    end

endmodule

// ==== logic/icache_way_if.sv ====
`timescale 1ns/10ps

interface icache_way_if #(
    parameter int SET_BITS = 6
);
    import icache_pkg::*;

    localparam int TAG_W = ADDR_W - SET_BITS - 3;

    logic [SET_BITS-1:0] index;
    logic [TAG_W-1:0]    rd_tag;
    logic                rd_valid;
    logic [LINE_W-1:0]   rd_data;
    logic                wr_en;
    logic [TAG_W-1:0]    wr_tag;
    logic [LINE_W-1:0]   wr_data;
    logic                flush;

    modport ctrl (
        output index, wr_en, wr_tag, wr_data, flush,
        input  rd_tag, rd_valid, rd_data
    );

    modport way (
        input  index, wr_en, wr_tag, wr_data, flush,
        output rd_tag, rd_valid, rd_data
    );

endinterface

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module icache_tb -f icache.f \
    --Mdir obj_dir -o icache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== test/icache_mem_model.sv ====
`timescale 1ns/10ps

module icache_mem_model #(
    parameter int MIN_LAT = 1,
    parameter int MAX_LAT = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_mem_req,
    input  logic [31:0] i_mem_addr,
    output logic        o_mem_valid,
    output logic [63:0] o_mem_data
);

    // line data is a fixed function of the line address
    function automatic logic [63:0] line_data(input logic [31:0] line_addr);
        return {line_addr ^ 32'hA5A5_0000, line_addr ^ 32'h0000_5A5A};
    endfunction

    initial begin
        logic [31:0] line_addr;
        int          latency;
        o_mem_valid = 1'b0;
        o_mem_data  = '0;
        forever begin
            @(posedge clk);
            if (rst && i_mem_req) begin
                line_addr = i_mem_addr;
                latency   = $urandom_range(MIN_LAT, MAX_LAT);
                // latency counted from the edge that sampled the request
                repeat (latency - 1) @(posedge clk);
                #1;
                o_mem_valid = 1'b1;
                o_mem_data  = line_data(line_addr);
                @(posedge clk);
                #1;
                o_mem_valid = 1'b0;
                o_mem_data  = '0;
            end
        end
    end

endmodule

// ==== test/icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb;
    import icache_pkg::*;

    localparam int SET_BITS        = 6;
    localparam int SETS            = 1 << SET_BITS;
    localparam int TAG_W           = ADDR_W - SET_BITS - 3;
    localparam int N_DIRECTED      = 18;
    localparam int N_RANDOM        = 40;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;

    logic              clk;
    logic              rst;
    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_addr;
    logic              fetch_valid;
    logic [INSN_W-1:0] fetch_data;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_valid;
    logic [LINE_W-1:0] mem_data;
    logic              cfg_wr;
    icache_reg_e       cfg_addr;
    logic [CFG_W-1:0]  cfg_wdata;
    logic [CFG_W-1:0]  cfg_rdata;

    // expectations for the fetch in flight
    bit                pending;
    bit                exp_hit;
    logic [ADDR_W-1:0] exp_mem_addr;
    logic [INSN_W-1:0] exp_data;
    int                cycle = 0;
    int                req_cycle;
    int                mvalid_cycle;
    int                mem_reqs;

    // reference model
    logic              ref_valid [2][SETS];
    logic [TAG_W-1:0]  ref_tag [2][SETS];
    logic              ref_lru [SETS];
    bit                ref_enable;
    int                ref_hits;
    int                ref_misses;

    icache_top #(.SET_BITS(SET_BITS)) dut (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .o_fetch_valid (fetch_valid),
        .o_fetch_data  (fetch_data),
        .o_mem_req     (mem_req),
        .o_mem_addr    (mem_addr),
        .i_mem_valid   (mem_valid),
        .i_mem_data    (mem_data),
        .i_cfg_wr      (cfg_wr),
        .i_cfg_addr    (cfg_addr),
        .i_cfg_wdata   (cfg_wdata),
        .o_cfg_rdata   (cfg_rdata)
    );

    icache_mem_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .i_mem_req   (mem_req),
        .i_mem_addr  (mem_addr),
        .o_mem_valid (mem_valid),
        .o_mem_data  (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // memory rule: high word for address bit 2 set, low word otherwise
    function automatic logic [INSN_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] line_addr;
        line_addr = {addr[ADDR_W-1:3], 3'b000};
        return addr[2] ? (line_addr ^ 32'hA5A5_0000) : (line_addr ^ 32'h0000_5A5A);
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst) begin
            if (fetch_req) begin
                req_cycle = cycle;
                mem_reqs  = 0;
            end
            if (mem_valid) begin
                mvalid_cycle = cycle;
            end
            if (mem_req) begin
                assert (pending && !exp_hit && mem_reqs == 0)
                    else report_failure("o_mem_req raised while no miss was outstanding");
                assert (mem_addr == exp_mem_addr)
                    else report_failure($sformatf("[ERROR] mem_addr got %h expected %h",
                                                  mem_addr, exp_mem_addr));
                assert (cycle - req_cycle == 2)
                    else report_failure("o_mem_req did not follow the fetch by 2 cycles");
                mem_reqs = mem_reqs + 1;
            end
            if (fetch_valid) begin
                assert (pending)
                    else report_failure("o_fetch_valid raised with no fetch outstanding");
                assert (fetch_data == exp_data)
                    else report_failure($sformatf("[ERROR] fetch_data got %h expected %h",
                                                  fetch_data, exp_data));
                if (exp_hit) begin
                    assert (cycle - req_cycle == 2)
                        else report_failure("hit response not 2 cycles after the fetch");
                end else begin
                    assert (mem_reqs == 1)
                        else report_failure("miss answered without one memory request");
                    assert (cycle - mvalid_cycle == 1)
                        else report_failure("miss response not 1 cycle after memory data");
                end
            end
        end
    end

    // want: 1 hit, 0 miss or bypass, -1 either
    task automatic fetch(input logic [ADDR_W-1:0] addr, input int want);
        logic [SET_BITS-1:0] idx;
        logic [TAG_W-1:0]    tag;
        logic                h0;
        logic                h1;
        logic                victim;
        int                  waited;
        idx = addr[SET_BITS+2:3];
        tag = addr[ADDR_W-1:SET_BITS+3];
        h0  = ref_valid[0][idx] && (ref_tag[0][idx] == tag);
        h1  = ref_valid[1][idx] && (ref_tag[1][idx] == tag);
        exp_hit = ref_enable && (h0 || h1);
        if (want >= 0) begin
            assert (exp_hit == (want == 1))
                else report_failure($sformatf("unexpected hit or miss at address %h", addr));
        end
        exp_mem_addr = {addr[ADDR_W-1:3], 3'b000};
        exp_data     = expected_word(addr);
        pending      = 1'b1;
        fetch_req    = 1'b1;
        fetch_addr   = addr;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
        waited    = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                report_failure($sformatf("no response to the fetch at address %h", addr));
            end
        end while (!fetch_valid);
        #1;
        pending = 1'b0;
        if (exp_hit) begin
            ref_hits++;
            ref_lru[idx] = !h1;
        end else if (ref_enable) begin
            ref_misses++;
            if (!ref_valid[0][idx]) begin
                victim = 1'b0;
            end else if (!ref_valid[1][idx]) begin
                victim = 1'b1;
            end else begin
                victim = ref_lru[idx];
            end
            ref_valid[victim][idx] = 1'b1;
            ref_tag[victim][idx]   = tag;
            ref_lru[idx]           = !victim;
        end
    endtask

    task automatic write_reg(input icache_reg_e addr, input logic [CFG_W-1:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
        if (addr == REG_CTRL) begin
            ref_enable = data[0];
            if (data[1]) begin
                for (int i = 0; i < SETS; i++) begin
                    ref_valid[0][i] = 1'b0;
                    ref_valid[1][i] = 1'b0;
                end
                // flush lands one cycle after the write
                @(posedge clk);
                #1;
            end
        end else if (addr == REG_HITS) begin
            ref_hits = 0;
        end else if (addr == REG_MISSES) begin
            ref_misses = 0;
        end
    endtask

    task automatic expect_reg(input icache_reg_e addr, input logic [CFG_W-1:0] expected);
        cfg_addr = addr;
        @(posedge clk);
        assert (cfg_rdata == expected)
            else report_failure($sformatf("[ERROR] cfg_rdata (%s) got %h expected %h",
                                          addr.name(), cfg_rdata, expected));
        #1;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin : main
        logic [ADDR_W-1:0] addr;
        void'($urandom(32'h7ab8_578e));
        rst          = 1'b0;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        cfg_wr       = 1'b0;
        cfg_addr     = REG_CTRL;
        cfg_wdata    = '0;
        pending      = 1'b0;
        exp_hit      = 1'b0;
        exp_mem_addr = '0;
        exp_data     = '0;
        for (int i = 0; i < SETS; i++) begin
            ref_valid[0][i] = 1'b0;
            ref_valid[1][i] = 1'b0;
            ref_tag[0][i]   = '0;
            ref_tag[1][i]   = '0;
            ref_lru[i]      = 1'b0;
        end
        ref_enable = 1'b1;
        ref_hits   = 0;
        ref_misses = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        // cold miss, then both halves hit
        fetch(32'h0000_1004, 0);
        fetch(32'h0000_1004, 1);
        fetch(32'h0000_1000, 1);
        // A, B, C share set 5
        fetch(32'h0001_0028, 0);
        fetch(32'h0002_0028, 0);
        fetch(32'h0001_0028, 1);
        fetch(32'h0003_002c, 0);
        fetch(32'h0001_0028, 1);
        fetch(32'h0002_0028, 0);
        // flush with enable kept on
        write_reg(REG_CTRL, 32'h3);
        fetch(32'h0000_1004, 0);
        fetch(32'h0001_0028, 0);
        fetch(32'h0002_0028, 0);
        // bypass while disabled
        write_reg(REG_CTRL, 32'h0);
        fetch(32'h0000_2000, 0);
        fetch(32'h0000_2104, 0);
        fetch(32'h0000_1004, 0);
        write_reg(REG_CTRL, 32'h1);
        fetch(32'h0000_2000, 0);
        fetch(32'h0000_2104, 0);
        fetch(32'h0000_1000, 1);
        // random traffic over sets 0 to 3
        for (int n = 0; n < N_RANDOM; n++) begin
            addr = ($urandom_range(0, 3) << (SET_BITS + 3)) | ($urandom_range(0, 3) << 3)
                   | ($urandom_range(0, 1) << 2);
            fetch(addr, -1);
        end
        expect_reg(REG_HITS, ref_hits);
        expect_reg(REG_MISSES, ref_misses);
        expect_reg(REG_CTRL, 32'h1);
        write_reg(REG_HITS, 32'h0);
        write_reg(REG_MISSES, 32'h0);
        expect_reg(REG_HITS, 32'h0);
        expect_reg(REG_MISSES, 32'h0);
        $display("TB PASSED");
        $finish;
    end

endmodule
